// ==== list.f ====
verilog/axi_pkg.sv
verilog/cache_pkg.sv
verilog/line_refill.sv
verilog/line_writeback.sv
verilog/read_arbiter.sv
verilog/axi_cache_bridge.sv
testbench/axi_mem_model.sv
testbench/tb_axi_cache_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_axi_cache_bridge \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic             clk,
    input  logic [1:0]       id_allow,      // one bit per master id
    output int               proto_errors,
    input  axi_pkg::axi_ar_t ar,
    input  logic [1:0]       ar_burst,
    input  logic             ar_valid,
    output logic             ar_ready,
    output axi_pkg::axi_r_t  r,
    output logic             r_valid,
    input  logic             r_ready,
    input  axi_pkg::axi_aw_t aw,
    input  logic [1:0]       aw_burst,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  axi_pkg::axi_w_t  w,
    input  logic             w_valid,
    output logic             w_ready,
    output axi_pkg::axi_b_t  b,
    output logic             b_valid,
    input  logic             b_ready
);
    int                 seed = 21631;
    axi_pkg::word_t     mem [axi_pkg::addr_t];  // keyed by word address
    logic               ar_hs;
    logic               r_hs;
    logic               aw_hs;
    logic               w_hs;
    logic               b_hs;
    axi_pkg::axi_ar_t   ar_cap;
    axi_pkg::axi_aw_t   aw_cap;
    axi_pkg::axi_w_t    w_cap;
    axi_pkg::axi_ar_t   rd_q;
    axi_pkg::axi_aw_t   wr_q;
    logic               rd_busy;
    int                 rd_beat;
    int                 wr_beat;
    int                 wr_phase;  // 0 addr, 1 data, 2 response
    int                 ar_wait;
    int                 r_wait;
    int                 aw_wait;
    int                 w_wait;
    int                 b_wait;

    function automatic int rand_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    // untouched words follow the fill rule
    function automatic axi_pkg::word_t read_word(axi_pkg::addr_t a);
        if (mem.exists(a >> 2)) begin
            return mem[a >> 2];
        end
        return {2'b00, a[31:2]} ^ 32'hC0DE_0000;
    endfunction

    function automatic bit id_ok(axi_pkg::axi_id_t id);
        return (id == cache_pkg::id_icache && id_allow[0]) ||
               (id == cache_pkg::id_dcache && id_allow[1]);
    endfunction

    initial begin
        proto_errors = 0;
        ar_ready = 1'b0;
        r        = '0;
        r_valid  = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b        = '0;
        b_valid  = 1'b0;
        rd_busy  = 1'b0;
        wr_phase = 0;
        ar_wait  = 0;
        aw_wait  = 0;
    end

    // handshakes seen at the rising edge
    always @(posedge clk) begin
        ar_hs  <= ar_valid && ar_ready;
        r_hs   <= r_valid && r_ready;
        aw_hs  <= aw_valid && aw_ready;
        w_hs   <= w_valid && w_ready;
        b_hs   <= b_valid && b_ready;
        ar_cap <= ar;
        aw_cap <= aw;
        w_cap  <= w;
    end

    always @(negedge clk) begin
        if (ar_hs) begin
            ar_ready <= 1'b0;
            rd_q     <= ar_cap;
            rd_beat  <= 0;
            rd_busy  <= 1'b1;
            r_wait   <= rand_delay();
            ar_wait  <= rand_delay();
            if (!id_ok(ar_cap.id) || ar_burst != axi_pkg::burst_incr ||
                ar_cap.size != axi_pkg::size_word) begin
                proto_errors = proto_errors + 1;
            end
        end else if (!rd_busy && ar_valid && !ar_ready) begin
            if (ar_wait == 0) ar_ready <= 1'b1;
            else ar_wait <= ar_wait - 1;
        end

        if (r_hs) begin
            r_valid <= 1'b0;
            if (rd_beat == int'(rd_q.len)) begin
                rd_busy <= 1'b0;
            end else begin
                rd_beat <= rd_beat + 1;
                r_wait  <= rand_delay();
            end
        end else if (rd_busy && !ar_hs && !r_valid) begin
            if (r_wait == 0) begin
                r_valid <= 1'b1;
                r <= '{id: rd_q.id, data: read_word(rd_q.addr + 32'(4 * rd_beat)),
                       resp: axi_pkg::okay, last: (rd_beat == int'(rd_q.len))};
            end else begin
                r_wait <= r_wait - 1;
            end
        end

        if (aw_hs) begin
            aw_ready <= 1'b0;
            wr_q     <= aw_cap;
            wr_beat  <= 0;
            wr_phase <= 1;
            w_wait   <= rand_delay();
            aw_wait  <= rand_delay();
            if (!id_ok(aw_cap.id) || aw_burst != axi_pkg::burst_incr ||
                aw_cap.size != axi_pkg::size_word) begin
                proto_errors = proto_errors + 1;
            end
        end else if (wr_phase == 0 && aw_valid && !aw_ready) begin
            if (aw_wait == 0) aw_ready <= 1'b1;
            else aw_wait <= aw_wait - 1;
        end

        if (w_hs) begin
            w_ready <= 1'b0;
            if (wr_q.addr < 32'h8000_0000) begin  // error region stays untouched
                mem[(wr_q.addr >> 2) + 32'(wr_beat)] = w_cap.data;
            end
            if (w_cap.last != (wr_beat == int'(wr_q.len)) || w_cap.strb != '1) begin
                proto_errors = proto_errors + 1;
            end
            if (w_cap.last) begin
                wr_phase <= 2;
                b_wait   <= rand_delay();
            end else begin
                wr_beat <= wr_beat + 1;
                w_wait  <= rand_delay();
            end
        end else if (wr_phase == 1 && w_valid && !w_ready) begin
            if (w_wait == 0) w_ready <= 1'b1;
            else w_wait <= w_wait - 1;
        end

        if (b_hs) begin
            b_valid  <= 1'b0;
            wr_phase <= 0;
        end else if (wr_phase == 2 && !b_valid) begin
            if (b_wait == 0) begin
                b_valid <= 1'b1;
                b.id    <= wr_q.id;
                b.resp  <= (wr_q.addr >= 32'h8000_0000) ? axi_pkg::slverr : axi_pkg::okay;
            end else begin
                b_wait <= b_wait - 1;
            end
        end
    end

endmodule

// ==== testbench/bridge_golden.txt ====
# op addr [addr2], then 8 hex words per line (expected, or written for dwrite)
# dwrite ends with the expected resp code: 0 okay, 2 slverr
irefill 00000100
  c0de0040 c0de0041 c0de0042 c0de0043 c0de0044 c0de0045 c0de0046 c0de0047
drefill 01234560
  c096d158 c096d159 c096d15a c096d15b c096d15c c096d15d c096d15e c096d15f
dwrite 00000200
  11110000 22221111 33332222 44443333 55554444 66665555 77776666 88887777
  0
drefill 00000200
  11110000 22221111 33332222 44443333 55554444 66665555 77776666 88887777
dwrite 80000040
  ffff0000 ffff0001 ffff0002 ffff0003 ffff0004 ffff0005 ffff0006 ffff0007
  2
both 00000300 00000400
  c0de00c0 c0de00c1 c0de00c2 c0de00c3 c0de00c4 c0de00c5 c0de00c6 c0de00c7
  c0de0100 c0de0101 c0de0102 c0de0103 c0de0104 c0de0105 c0de0106 c0de0107
both 00000200 00001000
  11110000 22221111 33332222 44443333 55554444 66665555 77776666 88887777
  c0de0400 c0de0401 c0de0402 c0de0403 c0de0404 c0de0405 c0de0406 c0de0407
irefill 000ffe00
  c0ddff80 c0ddff81 c0ddff82 c0ddff83 c0ddff84 c0ddff85 c0ddff86 c0ddff87

// ==== testbench/tb_axi_cache_bridge.sv ====
`timescale 1ns/1ps

module tb_axi_cache_bridge;
    localparam int line_words      = 8;
    localparam int cycles_per_line = 200;

    typedef axi_pkg::word_t [line_words-1:0] line_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               ic_rd_req;
    axi_pkg::addr_t     ic_rd_addr;
    logic               ic_ret_valid;
    line_t              ic_ret_line;
    logic               dc_rd_req;
    axi_pkg::addr_t     dc_rd_addr;
    logic               dc_ret_valid;
    line_t              dc_ret_line;
    logic               dc_wr_req;
    axi_pkg::addr_t     dc_wr_addr;
    line_t              dc_wr_line;
    logic               dc_wb_done;
    axi_pkg::axi_resp_e dc_wb_resp;
    axi_pkg::axi_ar_t   m_ar;
    logic [1:0]         m_ar_burst;
    logic               m_ar_valid;
    logic               m_ar_ready;
    axi_pkg::axi_r_t    m_r;
    logic               m_r_valid;
    logic               m_r_ready;
    axi_pkg::axi_aw_t   m_aw;
    logic [1:0]         m_aw_burst;
    logic               m_aw_valid;
    logic               m_aw_ready;
    axi_pkg::axi_w_t    m_w;
    logic               m_w_valid;
    logic               m_w_ready;
    axi_pkg::axi_b_t    m_b;
    logic               m_b_valid;
    logic               m_b_ready;
    logic [1:0]         id_allow;
    int                 proto_errors;
    int                 fd;
    int                 limit;
    int                 cycles;
    int                 n_tests;
    int                 n_failed;
    bit                 test_ok;

    axi_cache_bridge #(
        .i_line_words (line_words),
        .d_line_words (line_words)
    ) u_axi_cache_bridge (.*);

    axi_mem_model u_mem (
        .clk (clk), .id_allow (id_allow), .proto_errors (proto_errors),
        .ar (m_ar), .ar_burst (m_ar_burst), .ar_valid (m_ar_valid), .ar_ready (m_ar_ready),
        .r (m_r), .r_valid (m_r_valid), .r_ready (m_r_ready),
        .aw (m_aw), .aw_burst (m_aw_burst), .aw_valid (m_aw_valid), .aw_ready (m_aw_ready),
        .w (m_w), .w_valid (m_w_valid), .w_ready (m_w_ready),
        .b (m_b), .b_valid (m_b_valid), .b_ready (m_b_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s line got %h expected %h", $time, what, got, exp);
            test_ok = 0;
        end
    endtask

    task automatic check_resp(input string what, input axi_pkg::axi_resp_e got,
                              input axi_pkg::axi_resp_e exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s resp got %s expected %s", $time, what,
                     got.name(), exp.name());
            test_ok = 0;
        end
    endtask

    task automatic read_addr(output axi_pkg::addr_t a);
        if ($fscanf(fd, "%h", a) != 1) begin
            $display("golden file has no address where one is due");
            test_ok = 0;
        end
    endtask

    task automatic read_line(output line_t line);
        axi_pkg::word_t v;
        for (int i = 0; i < line_words; i++) begin
            if ($fscanf(fd, "%h", v) != 1) begin
                $display("golden file ended inside a line");
                test_ok = 0;
            end
            line[i] = v;
        end
    endtask

    // strobe on a falling edge, collect returns in any order
    task automatic run_reads(input bit do_i, input bit do_d, input axi_pkg::addr_t ia,
                             input axi_pkg::addr_t da, output line_t i_line,
                             output line_t d_line);
        bit got_i;
        bit got_d;
        got_i = !do_i;
        got_d = !do_d;
        @(negedge clk);
        ic_rd_req  = do_i;
        ic_rd_addr = ia;
        dc_rd_req  = do_d;
        dc_rd_addr = da;
        @(negedge clk);
        ic_rd_req = 1'b0;
        dc_rd_req = 1'b0;
        while (!(got_i && got_d)) begin
            @(negedge clk);
            if (ic_ret_valid) begin
                got_i  = 1'b1;
                i_line = ic_ret_line;
            end
            if (dc_ret_valid) begin
                got_d  = 1'b1;
                d_line = dc_ret_line;
            end
        end
    endtask

    task automatic run_write(input axi_pkg::addr_t a, input line_t line,
                             output axi_pkg::axi_resp_e resp);
        @(negedge clk);
        dc_wr_req  = 1'b1;
        dc_wr_addr = a;
        dc_wr_line = line;
        @(negedge clk);
        dc_wr_req = 1'b0;
        while (!dc_wb_done) @(negedge clk);
        resp = dc_wb_resp;
    endtask

    task automatic run_test(input logic [63:0] op);
        axi_pkg::addr_t     ia;
        axi_pkg::addr_t     da;
        line_t              exp_i;
        line_t              exp_d;
        line_t              got_i;
        line_t              got_d;
        line_t              wdata;
        logic [1:0]         code;
        axi_pkg::axi_resp_e resp;
        int                 err_before;
        string              name;
        string              verdict;
        test_ok    = 1;
        err_before = proto_errors;
        ia         = '0;
        da         = '0;
        case (op)
            64'("irefill"): begin
                name = "irefill";
                read_addr(ia);
                read_line(exp_i);
                id_allow = 2'b01;
                run_reads(1'b1, 1'b0, ia, da, got_i, got_d);
                check_line("icache", got_i, exp_i);
            end
            64'("drefill"): begin
                name = "drefill";
                read_addr(da);
                read_line(exp_d);
                id_allow = 2'b10;  // AR must carry the dcache id
                run_reads(1'b0, 1'b1, ia, da, got_i, got_d);
                check_line("dcache", got_d, exp_d);
            end
            64'("dwrite"): begin
                name = "dwrite";
                read_addr(da);
                read_line(wdata);
                if ($fscanf(fd, "%h", code) != 1) begin
                    $display("golden file has no response code for dwrite");
                    test_ok = 0;
                end
                id_allow = 2'b10;
                run_write(da, wdata, resp);
                check_resp("writeback", resp, axi_pkg::axi_resp_e'(code));
            end
            64'("both"): begin
                name = "both";
                read_addr(ia);
                read_addr(da);
                read_line(exp_i);
                read_line(exp_d);
                id_allow = 2'b11;
                run_reads(1'b1, 1'b1, ia, da, got_i, got_d);
                check_line("icache", got_i, exp_i);
                check_line("dcache", got_d, exp_d);
            end
            default: begin
                name = "unknown";
                $display("golden file holds an operation that is not known");
                test_ok = 0;
            end
        endcase
        if (proto_errors != err_before) begin
            $display("memory model saw a wrong AXI id, burst, size, strobe or last flag");
            test_ok = 0;
        end
        n_tests++;
        if (test_ok) begin
            verdict = "ok";
        end else begin
            verdict = "FAILED";
            n_failed++;
        end
        $display("test %0d %s i_addr %h d_addr %h: %s", n_tests, name, ia, da, verdict);
    endtask

    initial begin
        logic [63:0]     op;
        logic [1023:0]   text;
        int              n_lines;
        rst_n      = 1'b0;
        ic_rd_req  = 1'b0;
        ic_rd_addr = '0;
        dc_rd_req  = 1'b0;
        dc_rd_addr = '0;
        dc_wr_req  = 1'b0;
        dc_wr_addr = '0;
        dc_wr_line = '0;
        id_allow   = 2'b11;
        n_lines    = 0;
        fd = $fopen("testbench/bridge_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/bridge_golden.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            while ($fgets(text, fd) > 0) begin
                n_lines++;
            end
            $fclose(fd);
            limit = n_lines * cycles_per_line;
            fd = $fopen("testbench/bridge_golden.txt", "r");

            repeat (10) @(negedge clk);
            rst_n = 1'b1;

            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == 64'("#")) begin
                    void'($fgets(text, fd));  // comment line
                end else begin
                    run_test(op);
                end
            end
            $fclose(fd);

            $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed,
                     n_failed);
            if (n_failed == 0 && n_tests > 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// ==== verilog/axi_cache_bridge.sv ====
`timescale 1ns/1ps

module axi_cache_bridge #(
    parameter int i_line_words = 8,
    parameter int d_line_words = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ic_rd_req,
    input  axi_pkg::addr_t                    ic_rd_addr,
    output logic                              ic_ret_valid,
    output axi_pkg::word_t [i_line_words-1:0] ic_ret_line,
    input  logic                              dc_rd_req,
    input  axi_pkg::addr_t                    dc_rd_addr,
    output logic                              dc_ret_valid,
    output axi_pkg::word_t [d_line_words-1:0] dc_ret_line,
    input  logic                              dc_wr_req,
    input  axi_pkg::addr_t                    dc_wr_addr,
    input  axi_pkg::word_t [d_line_words-1:0] dc_wr_line,
    output logic                              dc_wb_done,
    output axi_pkg::axi_resp_e                dc_wb_resp,
    output axi_pkg::axi_ar_t                  m_ar,
    output logic [1:0]                        m_ar_burst,
    output logic                              m_ar_valid,
    input  logic                              m_ar_ready,
    input  axi_pkg::axi_r_t                   m_r,
    input  logic                              m_r_valid,
    output logic                              m_r_ready,
    output axi_pkg::axi_aw_t                  m_aw,
    output logic [1:0]                        m_aw_burst,
    output logic                              m_aw_valid,
    input  logic                              m_aw_ready,
    output axi_pkg::axi_w_t                   m_w,
    output logic                              m_w_valid,
    input  logic                              m_w_ready,
    input  axi_pkg::axi_b_t                   m_b,
    input  logic                              m_b_valid,
    output logic                              m_b_ready
);
    axi_pkg::axi_ar_t i_ar;
    axi_pkg::axi_ar_t d_ar;
    logic             i_ar_valid;
    logic             i_ar_ready;
    logic             d_ar_valid;
    logic             d_ar_ready;
    logic             i_r_valid;
    logic             i_r_ready;
    logic             d_r_valid;
    logic             d_r_ready;

    // incrementing bursts only
    assign m_ar_burst = axi_pkg::burst_incr;
    assign m_aw_burst = axi_pkg::burst_incr;

    line_refill #(
        .line_words (i_line_words),
        .master_id  (cache_pkg::id_icache)
    ) u_i_refill (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (ic_rd_req),
        .rd_addr   (ic_rd_addr),
        .ret_valid (ic_ret_valid),
        .ret_line  (ic_ret_line),
        .ar        (i_ar),
        .ar_valid  (i_ar_valid),
        .ar_ready  (i_ar_ready),
        .r         (m_r),
        .r_valid   (i_r_valid),
        .r_ready   (i_r_ready)
    );

    line_refill #(
        .line_words (d_line_words),
        .master_id  (cache_pkg::id_dcache)
    ) u_d_refill (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (dc_rd_req),
        .rd_addr   (dc_rd_addr),
        .ret_valid (dc_ret_valid),
        .ret_line  (dc_ret_line),
        .ar        (d_ar),
        .ar_valid  (d_ar_valid),
        .ar_ready  (d_ar_ready),
        .r         (m_r),
        .r_valid   (d_r_valid),
        .r_ready   (d_r_ready)
    );

    // sole owner of the write channels
    line_writeback #(
        .line_words (d_line_words)
    ) u_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (dc_wr_req),
        .wr_addr  (dc_wr_addr),
        .wr_line  (dc_wr_line),
        .wb_done  (dc_wb_done),
        .wb_resp  (dc_wb_resp),
        .aw       (m_aw),
        .aw_valid (m_aw_valid),
        .aw_ready (m_aw_ready),
        .w        (m_w),
        .w_valid  (m_w_valid),
        .w_ready  (m_w_ready),
        .b        (m_b),
        .b_valid  (m_b_valid),
        .b_ready  (m_b_ready)
    );

    read_arbiter u_read_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ar       (i_ar),
        .i_ar_valid (i_ar_valid),
        .i_ar_ready (i_ar_ready),
        .d_ar       (d_ar),
        .d_ar_valid (d_ar_valid),
        .d_ar_ready (d_ar_ready),
        .i_r_valid  (i_r_valid),
        .i_r_ready  (i_r_ready),
        .d_r_valid  (d_r_valid),
        .d_r_ready  (d_r_ready),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready)
    );

endmodule

// ==== verilog/axi_pkg.sv ====
package axi_pkg;

    parameter int addr_w = 32;
    parameter int data_w = 32;
    parameter int id_w   = 4;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] word_t;
    typedef logic [id_w-1:0]   axi_id_t;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_word  = 3'b010;  // 4 bytes per beat

    // AR and AW carry the same fields
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [3:0] len;   // beats minus one
        logic [2:0] size;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        axi_id_t   id;
        word_t     data;
        axi_resp_e resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        word_t               data;
        logic [data_w/8-1:0] strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_e resp;
    } axi_b_t;

endpackage

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // refill engine
    typedef enum logic [1:0] {
        rf_idle,
        rf_req,   // AR pending
        rf_recv,  // collecting R beats
        rf_done   // line handed back
    } refill_state_e;

    // writeback engine
    typedef enum logic [1:0] {
        wb_idle,
        wb_addr,
        wb_data,
        wb_bresp  // waiting on B
    } wb_state_e;

    // R beats are routed back by this AXI id
    typedef enum logic [axi_pkg::id_w-1:0] {
        id_icache = 4'd0,
        id_dcache = 4'd1
    } master_id_e;

endpackage

// ==== verilog/line_refill.sv ====
`timescale 1ns/1ps

module line_refill #(
    parameter int                    line_words = 8,
    parameter cache_pkg::master_id_e master_id  = cache_pkg::id_icache
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rd_req,
    input  axi_pkg::addr_t                  rd_addr,
    output logic                            ret_valid,
    output axi_pkg::word_t [line_words-1:0] ret_line,
    output axi_pkg::axi_ar_t                ar,
    output logic                            ar_valid,
    input  logic                            ar_ready,
    input  axi_pkg::axi_r_t                 r,
    input  logic                            r_valid,
    output logic                            r_ready
);
    localparam int cnt_w = (line_words > 1) ? $clog2(line_words) : 1;

    cache_pkg::refill_state_e        state;
    cache_pkg::refill_state_e        state_next;
    axi_pkg::addr_t                  addr_q;
    logic [cnt_w-1:0]                beat_cnt;
    axi_pkg::word_t [line_words-1:0] line_q;
    logic                            beat_ok;

    assign beat_ok = r_valid && r_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::rf_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::rf_idle: begin
                if (rd_req) begin
                    state_next = cache_pkg::rf_req;
                end
            end
            cache_pkg::rf_req: begin
                if (ar_ready) begin
                    state_next = cache_pkg::rf_recv;
                end
            end
            cache_pkg::rf_recv: begin
                if (beat_ok && r.last) begin
                    state_next = cache_pkg::rf_done;
                end
            end
            default: state_next = cache_pkg::rf_idle;  // done lasts one cycle
        endcase
    end

    // cleared while the address is out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (state == cache_pkg::rf_req) begin
            beat_cnt <= '0;
        end else if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::rf_idle && rd_req) begin
            addr_q <= rd_addr;
        end
        if (beat_ok) begin
            line_q[beat_cnt] <= r.data;
        end
    end

    assign ar = '{id: master_id, addr: addr_q, len: 4'(line_words - 1),
                  size: axi_pkg::size_word};
    assign ar_valid  = (state == cache_pkg::rf_req);
    assign r_ready   = (state == cache_pkg::rf_recv);
    assign ret_valid = (state == cache_pkg::rf_done);
    assign ret_line  = line_q;

    // cache waits for ret_valid before the next strobe
    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> state == cache_pkg::rf_idle)
        else $error("rd_req while refill busy");

    // slave burst length must match the line
    a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
        beat_ok |-> (r.last == (beat_cnt == cnt_w'(line_words - 1))))
        else $error("rlast out of step with beat count");

endmodule

// ==== verilog/line_writeback.sv ====
`timescale 1ns/1ps

module line_writeback #(
    parameter int line_words = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_req,
    input  axi_pkg::addr_t                  wr_addr,
    input  axi_pkg::word_t [line_words-1:0] wr_line,
    output logic                            wb_done,
    output axi_pkg::axi_resp_e              wb_resp,
    output axi_pkg::axi_aw_t                aw,
    output logic                            aw_valid,
    input  logic                            aw_ready,
    output axi_pkg::axi_w_t                 w,
    output logic                            w_valid,
    input  logic                            w_ready,
    input  axi_pkg::axi_b_t                 b,
    input  logic                            b_valid,
    output logic                            b_ready
);
    localparam int cnt_w = (line_words > 1) ? $clog2(line_words) : 1;

    cache_pkg::wb_state_e            state;
    cache_pkg::wb_state_e            state_next;
    axi_pkg::addr_t                  addr_q;
    axi_pkg::word_t [line_words-1:0] line_q;
    logic [cnt_w-1:0]                beat_cnt;
    logic                            last_beat;
    logic                            done_q;
    axi_pkg::axi_resp_e              resp_q;

    assign last_beat = (beat_cnt == cnt_w'(line_words - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::wb_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::wb_idle: if (wr_req) state_next = cache_pkg::wb_addr;
            cache_pkg::wb_addr: if (aw_ready) state_next = cache_pkg::wb_data;
            cache_pkg::wb_data: if (w_ready && last_beat) state_next = cache_pkg::wb_bresp;
            default:            if (b_valid) state_next = cache_pkg::wb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= (state == cache_pkg::wb_bresp) && b_valid;  // one-cycle pulse
            if (state == cache_pkg::wb_addr) begin
                beat_cnt <= '0;
            end else if (w_valid && w_ready) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::wb_idle && wr_req) begin
            addr_q <= wr_addr;
            line_q <= wr_line;
        end
        if (b_valid && b_ready) begin
            resp_q <= b.resp;
        end
    end

    assign aw = '{id: cache_pkg::id_dcache, addr: addr_q, len: 4'(line_words - 1),
                  size: axi_pkg::size_word};
    assign aw_valid = (state == cache_pkg::wb_addr);
    assign w        = '{data: line_q[beat_cnt], strb: '1, last: last_beat};  // full words only
    assign w_valid  = (state == cache_pkg::wb_data);
    assign b_ready  = (state == cache_pkg::wb_bresp);
    assign wb_done  = done_q;
    assign wb_resp  = resp_q;

    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> state == cache_pkg::wb_idle)
        else $error("wr_req while writeback busy");

    // response must come back for the id sent on AW
    a_bid: assert property (@(posedge clk) disable iff (!rst_n)
        (b_valid && b_ready) |-> b.id == cache_pkg::id_dcache)
        else $error("bid does not match writeback id");

endmodule

// ==== verilog/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  axi_pkg::axi_ar_t i_ar,
    input  logic             i_ar_valid,
    output logic             i_ar_ready,
    input  axi_pkg::axi_ar_t d_ar,
    input  logic             d_ar_valid,
    output logic             d_ar_ready,
    output logic             i_r_valid,
    input  logic             i_r_ready,
    output logic             d_r_valid,
    input  logic             d_r_ready,
    output axi_pkg::axi_ar_t m_ar,
    output logic             m_ar_valid,
    input  logic             m_ar_ready,
    input  axi_pkg::axi_r_t  m_r,
    input  logic             m_r_valid,
    output logic             m_r_ready
);
    cache_pkg::master_id_e grant_q;
    cache_pkg::master_id_e grant;
    logic                  owned_q;      // grant frozen once AR is shown
    logic                  addr_sent_q;  // burst in flight
    logic                  sel_d;
    logic                  r_to_i;
    logic                  r_to_d;

    // dcache wins a tie
    assign grant = owned_q ? grant_q : (d_ar_valid ? cache_pkg::id_dcache : cache_pkg::id_icache);
    assign sel_d = (grant == cache_pkg::id_dcache);

    assign m_ar       = sel_d ? d_ar : i_ar;
    assign m_ar_valid = !addr_sent_q && (sel_d ? d_ar_valid : i_ar_valid);
    assign i_ar_ready = !addr_sent_q && !sel_d && m_ar_ready;
    assign d_ar_ready = !addr_sent_q && sel_d && m_ar_ready;

    assign r_to_i    = (m_r.id == cache_pkg::id_icache);
    assign r_to_d    = (m_r.id == cache_pkg::id_dcache);
    assign i_r_valid = m_r_valid && r_to_i;
    assign d_r_valid = m_r_valid && r_to_d;
    assign m_r_ready = (r_to_i && i_r_ready) || (r_to_d && d_r_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q     <= cache_pkg::id_icache;
            owned_q     <= 1'b0;
            addr_sent_q <= 1'b0;
        end else if (m_r_valid && m_r_ready && m_r.last) begin
            owned_q     <= 1'b0;
            addr_sent_q <= 1'b0;
        end else begin
            if (!owned_q && m_ar_valid) begin
                owned_q <= 1'b1;
                grant_q <= grant;
            end
            if (m_ar_valid && m_ar_ready) begin
                addr_sent_q <= 1'b1;
            end
        end
    end

    a_rid_grant: assert property (@(posedge clk) disable iff (!rst_n)
        m_r_valid |-> (addr_sent_q && m_r.id == grant_q))
        else $error("rid does not match current grant");

endmodule
